// ==== hdl/id_pkg.sv ====
package id_pkg;

  // Datapath and register index widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Instruction word field positions
  localparam int OPC_MSB    = 6;
  localparam int OPC_LSB    = 0;
  localparam int RD_MSB     = 11;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_MSB = 14;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_MSB    = 19;
  localparam int RS1_LSB    = 15;
  localparam int RS2_MSB    = 24;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_MSB = 31;
  localparam int FUNCT7_LSB = 25;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // Link value offset for JAL and JALR
  localparam logic [XLEN-1:0] PC_INCR = XLEN'(4);

  // ALU operations, compare ops used by branches
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_SLL  = 4'h2,
    ALU_SLT  = 4'h3,
    ALU_SLTU = 4'h4,
    ALU_XOR  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_OR   = 4'h8,
    ALU_AND  = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  // Forwarding source for rs1 and rs2
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  typedef enum logic [1:0] {
    OP_A_REG  = 2'b00,
    OP_A_PC   = 2'b01,
    OP_A_ZERO = 2'b10
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG = 1'b0,
    OP_B_IMM = 1'b1
  } op_b_sel_e;

  typedef enum logic {
    OP_C_REG = 1'b0,
    OP_C_BCH = 1'b1
  } op_c_sel_e;

  typedef enum logic [2:0] {
    IMMB_I      = 3'b000,
    IMMB_S      = 3'b001,
    IMMB_U      = 3'b010,
    IMMB_PCINCR = 3'b011
  } imm_b_sel_e;

  // Encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

endpackage

// ==== hdl/id_decoder.sv ====
module id_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  // ALU control and operand selects
  output id_pkg::alu_op_e         alu_op_o,
  output id_pkg::op_a_sel_e       op_a_sel_o,
  output id_pkg::op_b_sel_e       op_b_sel_o,
  output id_pkg::op_c_sel_e       op_c_sel_o,
  output id_pkg::imm_b_sel_e      imm_b_sel_o,
  // Register file
  output logic [1:0]              rf_re_o,
  output logic                    rf_we_o,
  // Load/store unit
  output logic                    lsu_en_o,
  output logic                    lsu_we_o,
  output id_pkg::lsu_size_e       lsu_size_o,
  // Control flow
  output logic                    alu_bch_o,
  output logic                    alu_jmp_o,
  output logic                    alu_jmpr_o,
  output logic                    illegal_o
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[OPC_MSB:OPC_LSB];
  assign funct3 = instr_i[FUNCT3_MSB:FUNCT3_LSB];
  assign funct7 = instr_i[FUNCT7_MSB:FUNCT7_LSB];

  always_comb begin
    // Plain register-register ADD unless the opcode says otherwise
    alu_op_o    = ALU_ADD;
    op_a_sel_o  = OP_A_REG;
    op_b_sel_o  = OP_B_REG;
    op_c_sel_o  = OP_C_REG;
    imm_b_sel_o = IMMB_I;
    rf_re_o     = 2'b00;
    rf_we_o     = 1'b0;
    lsu_en_o    = 1'b0;
    lsu_we_o    = 1'b0;
    // Size only matters when lsu_en_o is set
    lsu_size_o  = (funct3[1:0] == 2'b00) ? LSU_BYTE :
                  (funct3[1:0] == 2'b01) ? LSU_HALF : LSU_WORD;
    alu_bch_o   = 1'b0;
    alu_jmp_o   = 1'b0;
    alu_jmpr_o  = 1'b0;
    illegal_o   = 1'b0;

    case (opcode)
      OPC_OP_IMM: begin
        rf_re_o    = 2'b01;
        rf_we_o    = 1'b1;
        op_b_sel_o = OP_B_IMM;
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b001: begin
            alu_op_o  = ALU_SLL;
            illegal_o = (funct7 != 7'b0000000);
          end
          default: begin
            // 3'b101 is SRLI or SRAI depending on instr[30]
            alu_op_o  = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_o = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end

      OPC_OP: begin
        rf_re_o = 2'b11;
        rf_we_o = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
          {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
          {7'b0000000, 3'b001}: alu_op_o = ALU_SLL;
          {7'b0000000, 3'b010}: alu_op_o = ALU_SLT;
          {7'b0000000, 3'b011}: alu_op_o = ALU_SLTU;
          {7'b0000000, 3'b100}: alu_op_o = ALU_XOR;
          {7'b0000000, 3'b101}: alu_op_o = ALU_SRL;
          {7'b0100000, 3'b101}: alu_op_o = ALU_SRA;
          {7'b0000000, 3'b110}: alu_op_o = ALU_OR;
          {7'b0000000, 3'b111}: alu_op_o = ALU_AND;
          default:              illegal_o = 1'b1;
        endcase
      end

      // LUI adds the U immediate to a zero operand A
      OPC_LUI, OPC_AUIPC: begin
        rf_we_o     = 1'b1;
        op_a_sel_o  = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_U;
      end

      // Jumps compute the link value pc + 4 in the ALU
      OPC_JAL, OPC_JALR: begin
        rf_we_o     = 1'b1;
        alu_jmp_o   = 1'b1;
        op_a_sel_o  = OP_A_PC;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_PCINCR;
        if (opcode == OPC_JALR) begin
          rf_re_o    = 2'b01;
          alu_jmpr_o = 1'b1;
          illegal_o  = (funct3 != 3'b000);
        end
      end

      OPC_BRANCH: begin
        rf_re_o    = 2'b11;
        alu_bch_o  = 1'b1;
        // Branch target rides along in operand C
        op_c_sel_o = OP_C_BCH;
        case (funct3)
          3'b000:  alu_op_o = ALU_EQ;
          3'b001:  alu_op_o = ALU_NE;
          3'b100:  alu_op_o = ALU_LT;
          3'b101:  alu_op_o = ALU_GE;
          3'b110:  alu_op_o = ALU_LTU;
          3'b111:  alu_op_o = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end

      // Address is rs1 + I immediate
      OPC_LOAD: begin
        rf_re_o    = 2'b01;
        rf_we_o    = 1'b1;
        lsu_en_o   = 1'b1;
        op_b_sel_o = OP_B_IMM;
        illegal_o  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end

      // Address is rs1 + S immediate, rs2 goes out as write data
      OPC_STORE: begin
        rf_re_o     = 2'b11;
        lsu_en_o    = 1'b1;
        lsu_we_o    = 1'b1;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMMB_S;
        illegal_o   = funct3[2] || (funct3[1:0] == 2'b11);
      end

      default: illegal_o = 1'b1;
    endcase

    // Illegal words get no side effects but read both sources anyway
    if (illegal_o) begin
      rf_re_o    = 2'b11;
      rf_we_o    = 1'b0;
      lsu_en_o   = 1'b0;
      lsu_we_o   = 1'b0;
      alu_bch_o  = 1'b0;
      alu_jmp_o  = 1'b0;
      alu_jmpr_o = 1'b0;
    end
  end

endmodule

// ==== hdl/id_imm_gen.sv ====
module id_imm_gen (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  input  id_pkg::imm_b_sel_e      imm_b_sel_i,
  output logic [id_pkg::XLEN-1:0] imm_b_o,
  output logic [id_pkg::XLEN-1:0] imm_i_o,
  output logic [id_pkg::XLEN-1:0] imm_sb_o,
  output logic [id_pkg::XLEN-1:0] imm_uj_o
);
  import id_pkg::*;

  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_u;

  // All signed formats take their sign from instr[31]
  assign imm_i_o  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s    = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // B and J offsets are in halfwords so bit 0 is always zero
  assign imm_sb_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
  assign imm_uj_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  // Upper immediate fills the top 20 bits
  assign imm_u    = {instr_i[31:12], 12'b0};

  // Operand B immediate
  always_comb begin
    case (imm_b_sel_i)
      IMMB_I:      imm_b_o = imm_i_o;
      IMMB_S:      imm_b_o = imm_s;
      IMMB_U:      imm_b_o = imm_u;
      IMMB_PCINCR: imm_b_o = PC_INCR;
      default:     imm_b_o = imm_i_o;
    endcase
  end

endmodule

// ==== hdl/id_operand_mux.sv ====
module id_operand_mux (
  // Forwarding selects from the controller
  input  id_pkg::fw_sel_e         fw_sel_a_i,
  input  id_pkg::fw_sel_e         fw_sel_b_i,
  // Candidate data
  input  logic [id_pkg::XLEN-1:0] rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rf_rdata_b_i,
  input  logic [id_pkg::XLEN-1:0] rf_wdata_ex_i,
  input  logic [id_pkg::XLEN-1:0] rf_wdata_wb_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  logic [id_pkg::XLEN-1:0] imm_b_i,
  input  logic [id_pkg::XLEN-1:0] bch_target_i,
  // Decoder selects
  input  id_pkg::op_a_sel_e       op_a_sel_i,
  input  id_pkg::op_b_sel_e       op_b_sel_i,
  input  id_pkg::op_c_sel_e       op_c_sel_i,
  output logic [id_pkg::XLEN-1:0] operand_a_fw_o,
  output logic [id_pkg::XLEN-1:0] operand_a_o,
  output logic [id_pkg::XLEN-1:0] operand_b_o,
  output logic [id_pkg::XLEN-1:0] operand_c_o
);
  import id_pkg::*;

  logic [XLEN-1:0] operand_b_fw;

  ////////////////////
  // Forwarding
  ////////////////////

  // Newest result wins, EX is younger than WB
  always_comb begin
    case (fw_sel_a_i)
      SEL_FW_EX: operand_a_fw_o = rf_wdata_ex_i;
      SEL_FW_WB: operand_a_fw_o = rf_wdata_wb_i;
      default:   operand_a_fw_o = rf_rdata_a_i;
    endcase
  end

  always_comb begin
    case (fw_sel_b_i)
      SEL_FW_EX: operand_b_fw = rf_wdata_ex_i;
      SEL_FW_WB: operand_b_fw = rf_wdata_wb_i;
      default:   operand_b_fw = rf_rdata_b_i;
    endcase
  end

  ////////////////////
  // Operand select
  ////////////////////

  // Zero operand A turns LUI into 0 + U immediate
  always_comb begin
    case (op_a_sel_i)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = operand_a_fw_o;
    endcase
  end

  assign operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b_i : operand_b_fw;

  // Store data or branch target
  assign operand_c_o = (op_c_sel_i == OP_C_BCH) ? bch_target_i : operand_b_fw;

endmodule

// ==== hdl/id_pc_target.sv ====
module id_pc_target (
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  logic [id_pkg::XLEN-1:0] imm_sb_i,
  input  logic [id_pkg::XLEN-1:0] imm_uj_i,
  input  logic [id_pkg::XLEN-1:0] imm_i_i,
  // Forwarded rs1 for JALR
  input  logic [id_pkg::XLEN-1:0] jalr_base_i,
  input  logic                    alu_jmpr_i,
  output logic [id_pkg::XLEN-1:0] bch_target_o,
  output logic [id_pkg::XLEN-1:0] jmp_target_o
);
  import id_pkg::*;

  logic [XLEN-1:0] jal_target;
  logic [XLEN-1:0] jalr_sum;

  // Branch target is computed for every branch whether taken or not
  assign bch_target_o = pc_i + imm_sb_i;

  assign jal_target = pc_i + imm_uj_i;
  assign jalr_sum   = jalr_base_i + imm_i_i;

  // JALR drops bit 0 of the sum
  assign jmp_target_o = alu_jmpr_i ? {jalr_sum[XLEN-1:1], 1'b0} : jal_target;

endmodule

// ==== hdl/id_ex_pipe.sv ====
module id_ex_pipe (
  input  logic                          clk,
  input  logic                          rst_n,
  // Handshake
  input  logic                          instr_valid_i,
  input  logic                          kill_i,
  input  logic                          halt_i,
  input  logic                          ex_ready_i,
  output logic                          id_ready_o,
  output logic                          ex_valid_o,
  // Decoded instruction from ID
  input  logic [id_pkg::XLEN-1:0]       operand_a_i,
  input  logic [id_pkg::XLEN-1:0]       operand_b_i,
  input  logic [id_pkg::XLEN-1:0]       operand_c_i,
  input  id_pkg::alu_op_e               alu_op_i,
  input  logic                          rf_we_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rf_waddr_i,
  input  logic                          lsu_en_i,
  input  logic                          lsu_we_i,
  input  id_pkg::lsu_size_e             lsu_size_i,
  input  logic                          alu_bch_i,
  input  logic                          alu_jmp_i,
  input  logic                          illegal_i,
  input  logic [id_pkg::XLEN-1:0]       pc_i,
  // Registered fields toward EX
  output logic [id_pkg::XLEN-1:0]       ex_operand_a_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_b_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_c_o,
  output id_pkg::alu_op_e               ex_alu_op_o,
  output logic                          ex_rf_we_o,
  output logic [id_pkg::REG_ADDR_W-1:0] ex_rf_waddr_o,
  output logic                          ex_lsu_en_o,
  output logic                          ex_lsu_we_o,
  output id_pkg::lsu_size_e             ex_lsu_size_o,
  output logic                          ex_alu_bch_o,
  output logic                          ex_alu_jmp_o,
  output logic                          ex_illegal_o,
  output logic [id_pkg::XLEN-1:0]       ex_pc_o
);
  import id_pkg::*;

  logic id_valid;
  logic transfer;

  // Kill and halt both keep the instruction out of EX
  assign id_valid   = instr_valid_i && !kill_i && !halt_i;
  // A killed instruction is dropped at once so IF may refill
  assign id_ready_o = kill_i || (ex_ready_i && !halt_i);
  assign transfer   = id_valid && ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_alu_op_o    <= ALU_ADD;
      ex_rf_we_o     <= 1'b0;
      ex_rf_waddr_o  <= '0;
      ex_lsu_en_o    <= 1'b0;
      ex_lsu_we_o    <= 1'b0;
      ex_lsu_size_o  <= LSU_BYTE;
      ex_alu_bch_o   <= 1'b0;
      ex_alu_jmp_o   <= 1'b0;
      ex_illegal_o   <= 1'b0;
      ex_pc_o        <= '0;
    end else if (transfer) begin
      ex_valid_o     <= 1'b1;
      ex_operand_a_o <= operand_a_i;
      ex_operand_b_o <= operand_b_i;
      ex_operand_c_o <= operand_c_i;
      ex_alu_op_o    <= alu_op_i;
      ex_rf_we_o     <= rf_we_i;
      ex_rf_waddr_o  <= rf_waddr_i;
      ex_lsu_en_o    <= lsu_en_i;
      ex_lsu_we_o    <= lsu_we_i;
      ex_lsu_size_o  <= lsu_size_i;
      ex_alu_bch_o   <= alu_bch_i;
      ex_alu_jmp_o   <= alu_jmp_i;
      ex_illegal_o   <= illegal_i;
      ex_pc_o        <= pc_i;
    end else if (ex_ready_i) begin
      // EX consumed its slot and nothing new arrived
      ex_valid_o <= 1'b0;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Stalled EX sees the same instruction on the next cycle
  a_hold_on_stall : assert property (
    @(posedge clk) disable iff (!rst_n)
    (ex_valid_o && !ex_ready_i) |=> ex_valid_o && $stable({ex_operand_a_o, ex_operand_b_o,
      ex_operand_c_o, ex_alu_op_o, ex_rf_we_o, ex_rf_waddr_o, ex_lsu_en_o, ex_lsu_we_o,
      ex_lsu_size_o, ex_alu_bch_o, ex_alu_jmp_o, ex_illegal_o, ex_pc_o})
  );

  // Valid only appears behind an accepted transfer
  a_valid_from_transfer : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(ex_valid_o) |-> $past(id_valid && ex_ready_i)
  );

  // Decoder must have stripped side effects from illegal words
  a_illegal_no_side_effect : assert property (
    @(posedge clk) disable iff (!rst_n)
    ex_illegal_o |-> !(ex_rf_we_o || ex_lsu_en_o)
  );

endmodule

// ==== hdl/id_stage.sv ====
module id_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  // IF to ID
  input  logic                          instr_valid_i,
  input  logic [id_pkg::XLEN-1:0]       instr_i,
  input  logic [id_pkg::XLEN-1:0]       pc_i,
  output logic                          id_ready_o,
  // Controller
  input  logic                          kill_i,
  input  logic                          halt_i,
  input  id_pkg::fw_sel_e               fw_sel_a_i,
  input  id_pkg::fw_sel_e               fw_sel_b_i,
  // Forwarded results
  input  logic [id_pkg::XLEN-1:0]       rf_wdata_ex_i,
  input  logic [id_pkg::XLEN-1:0]       rf_wdata_wb_i,
  // Register file read ports
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [1:0]                    rf_re_o,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_b_i,
  // Combinational jump target to IF
  output logic [id_pkg::XLEN-1:0]       jmp_target_o,
  // ID to EX
  input  logic                          ex_ready_i,
  output logic                          ex_valid_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_a_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_b_o,
  output logic [id_pkg::XLEN-1:0]       ex_operand_c_o,
  output id_pkg::alu_op_e               ex_alu_op_o,
  output logic                          ex_rf_we_o,
  output logic [id_pkg::REG_ADDR_W-1:0] ex_rf_waddr_o,
  output logic                          ex_lsu_en_o,
  output logic                          ex_lsu_we_o,
  output id_pkg::lsu_size_e             ex_lsu_size_o,
  output logic                          ex_alu_bch_o,
  output logic                          ex_alu_jmp_o,
  output logic                          ex_illegal_o,
  output logic [id_pkg::XLEN-1:0]       ex_pc_o
);
  import id_pkg::*;

  // Decoder control
  alu_op_e    alu_op;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  op_c_sel_e  op_c_sel;
  imm_b_sel_e imm_b_sel;
  lsu_size_e  lsu_size;
  logic       rf_we;
  logic       lsu_en;
  logic       lsu_we;
  logic       alu_bch;
  logic       alu_jmp;
  logic       alu_jmpr;
  logic       illegal;

  // Datapath
  logic [XLEN-1:0]       imm_b;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_sb;
  logic [XLEN-1:0]       imm_uj;
  logic [XLEN-1:0]       bch_target;
  logic [XLEN-1:0]       operand_a_fw;
  logic [XLEN-1:0]       operand_a;
  logic [XLEN-1:0]       operand_b;
  logic [XLEN-1:0]       operand_c;
  logic [REG_ADDR_W-1:0] rf_waddr;

  // Source and destination fields sit at fixed positions in every format
  assign rf_raddr_a_o = instr_i[RS1_MSB:RS1_LSB];
  assign rf_raddr_b_o = instr_i[RS2_MSB:RS2_LSB];
  assign rf_waddr     = instr_i[RD_MSB:RD_LSB];

  ////////////////////
  // Decode
  ////////////////////

  id_decoder i_decoder (
    .instr_i     (instr_i),
    .alu_op_o    (alu_op),
    .op_a_sel_o  (op_a_sel),
    .op_b_sel_o  (op_b_sel),
    .op_c_sel_o  (op_c_sel),
    .imm_b_sel_o (imm_b_sel),
    .rf_re_o     (rf_re_o),
    .rf_we_o     (rf_we),
    .lsu_en_o    (lsu_en),
    .lsu_we_o    (lsu_we),
    .lsu_size_o  (lsu_size),
    .alu_bch_o   (alu_bch),
    .alu_jmp_o   (alu_jmp),
    .alu_jmpr_o  (alu_jmpr),
    .illegal_o   (illegal)
  );

  id_imm_gen i_imm_gen (
    .instr_i     (instr_i),
    .imm_b_sel_i (imm_b_sel),
    .imm_b_o     (imm_b),
    .imm_i_o     (imm_i),
    .imm_sb_o    (imm_sb),
    .imm_uj_o    (imm_uj)
  );

  ////////////////////
  // Targets and operands
  ////////////////////

  // JALR base comes from the rs1 forwarding mux
  id_pc_target i_pc_target (
    .pc_i         (pc_i),
    .imm_sb_i     (imm_sb),
    .imm_uj_i     (imm_uj),
    .imm_i_i      (imm_i),
    .jalr_base_i  (operand_a_fw),
    .alu_jmpr_i   (alu_jmpr),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o)
  );

  id_operand_mux i_operand_mux (
    .fw_sel_a_i     (fw_sel_a_i),
    .fw_sel_b_i     (fw_sel_b_i),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .rf_wdata_ex_i  (rf_wdata_ex_i),
    .rf_wdata_wb_i  (rf_wdata_wb_i),
    .pc_i           (pc_i),
    .imm_b_i        (imm_b),
    .bch_target_i   (bch_target),
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .op_c_sel_i     (op_c_sel),
    .operand_a_fw_o (operand_a_fw),
    .operand_a_o    (operand_a),
    .operand_b_o    (operand_b),
    .operand_c_o    (operand_c)
  );

  ////////////////////
  // ID/EX register
  ////////////////////

  id_ex_pipe i_id_ex_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .kill_i         (kill_i),
    .halt_i         (halt_i),
    .ex_ready_i     (ex_ready_i),
    .id_ready_o     (id_ready_o),
    .ex_valid_o     (ex_valid_o),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .operand_c_i    (operand_c),
    .alu_op_i       (alu_op),
    .rf_we_i        (rf_we),
    .rf_waddr_i     (rf_waddr),
    .lsu_en_i       (lsu_en),
    .lsu_we_i       (lsu_we),
    .lsu_size_i     (lsu_size),
    .alu_bch_i      (alu_bch),
    .alu_jmp_i      (alu_jmp),
    .illegal_i      (illegal),
    .pc_i           (pc_i),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rf_waddr_o  (ex_rf_waddr_o),
    .ex_lsu_en_o    (ex_lsu_en_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_lsu_size_o  (ex_lsu_size_o),
    .ex_alu_bch_o   (ex_alu_bch_o),
    .ex_alu_jmp_o   (ex_alu_jmp_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_pc_o        (ex_pc_o)
  );

endmodule

// ==== verification/tb_id_stage.sv ====
module tb_id_stage;
  import id_pkg::*;

  localparam int HALF_PERIOD = 5;
  localparam int RST_CYCLES  = 10;
  localparam int NUM_VECS    = 20;
  // Five stimulus words then six expected words per golden line
  localparam int VEC_WORDS   = 11;
  localparam int CYCLE_LIMIT = RST_CYCLES + NUM_VECS + 20;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  logic                  instr_valid_i;
  logic [XLEN-1:0]       instr_i;
  logic [XLEN-1:0]       pc_i;
  logic                  kill_i;
  logic                  halt_i;
  fw_sel_e               fw_sel_a_i;
  fw_sel_e               fw_sel_b_i;
  logic [XLEN-1:0]       rf_wdata_ex_i;
  logic [XLEN-1:0]       rf_wdata_wb_i;
  logic [XLEN-1:0]       rf_rdata_a_i;
  logic [XLEN-1:0]       rf_rdata_b_i;
  logic                  ex_ready_i;

  // DUT outputs
  logic                  id_ready_o;
  logic [REG_ADDR_W-1:0] rf_raddr_a_o;
  logic [REG_ADDR_W-1:0] rf_raddr_b_o;
  logic [1:0]            rf_re_o;
  logic [XLEN-1:0]       jmp_target_o;
  logic                  ex_valid_o;
  logic [XLEN-1:0]       ex_operand_a_o;
  logic [XLEN-1:0]       ex_operand_b_o;
  logic [XLEN-1:0]       ex_operand_c_o;
  alu_op_e               ex_alu_op_o;
  logic                  ex_rf_we_o;
  logic [REG_ADDR_W-1:0] ex_rf_waddr_o;
  logic                  ex_lsu_en_o;
  logic                  ex_lsu_we_o;
  lsu_size_e             ex_lsu_size_o;
  logic                  ex_alu_bch_o;
  logic                  ex_alu_jmp_o;
  logic                  ex_illegal_o;
  logic [XLEN-1:0]       ex_pc_o;

  logic [31:0] golden_mem [0:NUM_VECS*VEC_WORDS-1];
  int          vec_idx;
  int          cycle_count = 0;

  id_stage i_dut (.*);

  always #HALF_PERIOD clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  // Register file model, every register holds a pattern of its own index
  function automatic logic [31:0] regfile_data(input logic [4:0] addr);
    return 32'h1000_0000 | {19'h0, addr, 3'b000, addr};
  endfunction

  // Same-cycle register file answer to the addresses ID drives
  assign rf_rdata_a_i = regfile_data(rf_raddr_a_o);
  assign rf_rdata_b_i = regfile_data(rf_raddr_b_o);

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s at vector %0d: got 0x%08h expected 0x%08h",
               name, vec_idx, actual, expected);
      $display("tests failed");
      $fatal(1, "output mismatch");
    end
  endtask

  // Ctrl word holds {valid, kill, halt, ex_ready} then fw_sel_a then fw_sel_b
  task automatic apply_vector(input int idx);
    logic [31:0] ctrl;
    int          base;
    base          = idx * VEC_WORDS;
    ctrl          = golden_mem[base];
    instr_valid_i = ctrl[11];
    kill_i        = ctrl[10];
    halt_i        = ctrl[9];
    ex_ready_i    = ctrl[8];
    fw_sel_a_i    = fw_sel_e'(ctrl[5:4]);
    fw_sel_b_i    = fw_sel_e'(ctrl[1:0]);
    instr_i       = golden_mem[base+1];
    pc_i          = golden_mem[base+2];
    rf_wdata_ex_i = golden_mem[base+3];
    rf_wdata_wb_i = golden_mem[base+4];
  endtask

  task automatic compare_vector(input int idx);
    logic [31:0] st;
    int          base;
    base = idx * VEC_WORDS + 5;
    st   = golden_mem[base];
    check_value("id_ready_o", 32'(id_ready_o), 32'(st[31]));
    check_value("ex_valid_o", 32'(ex_valid_o), 32'(st[30]));
    check_value("ex_rf_we_o", 32'(ex_rf_we_o), 32'(st[29]));
    check_value("ex_lsu_en_o", 32'(ex_lsu_en_o), 32'(st[28]));
    check_value("ex_lsu_we_o", 32'(ex_lsu_we_o), 32'(st[27]));
    check_value("ex_alu_bch_o", 32'(ex_alu_bch_o), 32'(st[26]));
    check_value("ex_alu_jmp_o", 32'(ex_alu_jmp_o), 32'(st[25]));
    check_value("ex_illegal_o", 32'(ex_illegal_o), 32'(st[24]));
    check_value("ex_alu_op_o", 32'(ex_alu_op_o), 32'(st[23:20]));
    check_value("rf_re_o", 32'(rf_re_o), 32'(st[19:18]));
    check_value("ex_lsu_size_o", 32'(ex_lsu_size_o), 32'(st[17:16]));
    check_value("rf_raddr_a_o", 32'(rf_raddr_a_o), 32'(st[12:8]));
    check_value("ex_rf_waddr_o", 32'(ex_rf_waddr_o), 32'(st[4:0]));
    // rs2 address shows up in the register file pattern of operands B and C
    check_value("ex_operand_a_o", ex_operand_a_o, golden_mem[base+1]);
    check_value("ex_operand_b_o", ex_operand_b_o, golden_mem[base+2]);
    check_value("ex_operand_c_o", ex_operand_c_o, golden_mem[base+3]);
    check_value("jmp_target_o", jmp_target_o, golden_mem[base+4]);
    check_value("ex_pc_o", ex_pc_o, golden_mem[base+5]);
  endtask

  ////////////////////
  // Run control
  ////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    fw_sel_a_i    = SEL_REGFILE;
    fw_sel_b_i    = SEL_REGFILE;
    rf_wdata_ex_i = '0;
    rf_wdata_wb_i = '0;
    ex_ready_i    = 1'b0;
    $readmemh("verification/id_stage_golden.txt", golden_mem);

    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Drive at the falling edge, sample one unit before the next one
    for (vec_idx = 0; vec_idx < NUM_VECS; vec_idx++) begin
      @(negedge clk);
      apply_vector(vec_idx);
      @(posedge clk);
      #(HALF_PERIOD - 1);
      compare_vector(vec_idx);
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== verification/id_stage_golden.txt ====
// ctrl{valid,kill,halt,ex_ready|fw_a|fw_b} instr pc wdata_ex wdata_wb, then expected:
// status{id_rdy,ex_vld,we,lsu_en|lsu_we,bch,jmp,ill|alu_op|rf_re,size|raddr_a|waddr}
// ex_operand_a ex_operand_b ex_operand_c jmp_target ex_pc
100 00000013 00000100 EEEE1111 BBBB2222 80040000 00000000 00000000 00000000 00000100 00000000
900 FFD08293 00000104 EEEE1111 BBBB2222 E0040105 10000101 FFFFFFFD 10001D1D FFF09100 00000104
900 12345337 00000108 EEEE1111 BBBB2222 E0010806 00000000 12345000 10000303 00045A2A 00000108
900 00001397 0000010C EEEE1111 BBBB2222 E0010007 0000010C 00001000 10000000 0000110C 0000010C
900 00310433 00000110 EEEE1111 BBBB2222 E00C0208 10000202 10000303 10000303 00010912 00000110
912 403104B3 00000114 EEEE1111 BBBB2222 E01C0209 EEEE1111 BBBB2222 BBBB2222 00010D16 00000114
921 00314533 00000118 EEEE1111 BBBB2222 E05C020A BBBB2222 EEEE1111 EEEE1111 0001491A 00000118
900 00412423 0000011C EEEE1111 BBBB2222 D80E0208 10000202 00000008 10000404 00012120 0000011C
900 FFF18503 00000120 EEEE1111 BBBB2222 F004030A 10000303 FFFFFFFF 10001F1F FFF1911E 00000120
900 010000EF 00000124 EEEE1111 BBBB2222 E2000001 00000124 00000004 10001010 00000134 00000124
910 004280E7 00000128 EEEE1111 BBBB2222 E2040501 00000128 00000004 10000404 EEEE1114 00000128
900 FE310CE3 0000012C EEEE1111 BBBB2222 C4AC0219 10000202 10000303 00000124 FFF1110E 0000012C
800 0F037593 00000130 EEEE1111 BBBB2222 44A40619 10000202 10000303 00000124 00037220 0000012C
812 0F037593 00000130 EEEE1111 BBBB2222 44A40619 10000202 10000303 00000124 00037220 0000012C
900 0F037593 00000130 EEEE1111 BBBB2222 E096060B 10000606 000000F0 10001010 00037220 00000130
D00 00310433 00000134 EEEE1111 BBBB2222 A09E020B 10000606 000000F0 10001010 00010936 00000130
B00 00310433 00000134 EEEE1111 BBBB2222 209E020B 10000606 000000F0 10001010 00010936 00000130
902 FE709F23 00000138 EEEE1111 BBBB2222 D80D011E 10000101 FFFFFFFE BBBB2222 FFF0A11E 00000138
900 FFFFFFFF 0000013C EEEE1111 BBBB2222 C10E1F1F 10001F1F 10001F1F 10001F1F 0000013A 0000013C
100 00000013 00000140 EEEE1111 BBBB2222 8106001F 10001F1F 10001F1F 10001F1F 00000140 0000013C

// ==== all.f ====
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_imm_gen.sv
hdl/id_operand_mux.sv
hdl/id_pc_target.sv
hdl/id_ex_pipe.sv
hdl/id_stage.sv
verification/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_id_stage -f all.f -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_id_stage)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
